// File: design/lsuPkg.sv
`default_nettype none

package lsuPkg;

    localparam int NUM_LANES = 2;
    localparam int LANE_BITS = $clog2(NUM_LANES);
    localparam int ID_BITS   = 6;
    localparam int PREG_BITS = 6;
    localparam int RAM_WORDS = 256;
    localparam int RAM_BITS  = $clog2(RAM_WORDS);

    // Unmapped windows, 512 MB each, both folded onto physical zero
    localparam logic [31:0] KSEG0_BASE = 32'h8000_0000;
    localparam logic [31:0] KSEG1_BASE = 32'hA000_0000;

    typedef enum logic [3:0] {
        LB,
        LH,
        LBU,
        LHU,
        LW,
        SB,
        SH,
        SW,
        NOP
    } MemOp;

    typedef enum logic {
        ADEL,
        ADES
    } ExcCode;

    function automatic logic isLoad(MemOp op);
        return op inside {LB, LH, LBU, LHU, LW};
    endfunction

    function automatic logic isStore(MemOp op);
        return op inside {SB, SH, SW};
    endfunction

    // Word ops need both low bits clear, halfword ops only bit 0
    function automatic logic misaligned(MemOp op, logic [1:0] low);
        case (op)
            LW, SW:      return |low;
            LH, LHU, SH: return low[0];
            default:     return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] physAddr(logic [31:0] va);
        case (va[31:29])
            3'b100:  return va - KSEG0_BASE;
            3'b101:  return va - KSEG1_BASE;
            default: return va;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: design/lsuIssue.sv
`default_nettype none

module lsuIssue import lsuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueReq,
    input  MemOp                 issueOp,
    input  logic [ID_BITS-1:0]   issueId,
    input  logic [PREG_BITS-1:0] issueDst,
    input  logic [31:0]          issueBase,
    input  logic [31:0]          issueImm,
    input  logic [31:0]          issueStoreData,
    input  logic                 fireStore,
    input  logic                 flush,
    input  logic [NUM_LANES-1:0] laneBusy,
    output logic                 issueAck,
    output logic [NUM_LANES-1:0] laneStart,
    output MemOp                 laneOp,
    output logic [ID_BITS-1:0]   laneId,
    output logic [PREG_BITS-1:0] laneDst,
    output logic [31:0]          laneBase,
    output logic [31:0]          laneImm,
    output logic [31:0]          laneStoreData,
    output logic [NUM_LANES-1:0] laneFire
);

    logic [LANE_BITS-1:0] pick;
    logic                 anyFree;
    logic                 accept;
    logic                 push;
    logic                 pop;

    // Lanes holding accepted stores, oldest at rdPtr
    logic [LANE_BITS-1:0] order [NUM_LANES];
    logic [LANE_BITS-1:0] wrPtr;
    logic [LANE_BITS-1:0] rdPtr;
    logic [LANE_BITS:0]   count;

    function automatic logic [LANE_BITS-1:0] nextPtr(logic [LANE_BITS-1:0] p);
        return (p == LANE_BITS'(NUM_LANES - 1)) ? '0 : p + 1'b1;
    endfunction

    // Lowest free lane
    always_comb begin
        pick    = '0;
        anyFree = 1'b0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (!laneBusy[i] && !laneStart[i]) begin
                pick    = LANE_BITS'(i);
                anyFree = 1'b1;
            end
        end
    end

    assign accept = issueReq && !issueAck && !flush && anyFree;
    assign push   = accept && isStore(issueOp);
    assign pop    = fireStore && count != 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueAck  <= 1'b0;
            laneStart <= '0;
        end else begin
            laneStart <= '0;
            if (accept) begin
                issueAck  <= 1'b1;
                laneStart <= NUM_LANES'(1) << pick;
            end else if (issueAck && !issueReq) begin
                issueAck <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            laneOp        <= issueOp;
            laneId        <= issueId;
            laneDst       <= issueDst;
            laneBase      <= issueBase;
            laneImm       <= issueImm;
            laneStoreData <= issueStoreData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Store order FIFO
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                order[wrPtr] <= pick;
                wrPtr        <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + {{LANE_BITS{1'b0}}, push} - {{LANE_BITS{1'b0}}, pop};
        end
    end

    // A fired store survives a flush in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            laneFire <= '0;
        end else begin
            laneFire <= pop ? NUM_LANES'(1) << order[rdPtr] : '0;
        end
    end

    // ROB may only retire stores this unit has accepted
    assert property (@(posedge clk) disable iff (rst) fireStore |-> count != 0);

endmodule

`default_nettype wire

// File: design/lsuLane.sv
`default_nettype none

module lsuLane import lsuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 start,
    input  MemOp                 op,
    input  logic [ID_BITS-1:0]   id,
    input  logic [PREG_BITS-1:0] dst,
    input  logic [31:0]          base,
    input  logic [31:0]          imm,
    input  logic [31:0]          storeData,
    input  logic                 fire,
    input  logic                 memAck,
    input  logic [31:0]          memRdata,
    input  logic                 doneTake,
    output logic                 busy,
    output logic                 memReq,
    output logic                 memWrite,
    output logic [31:0]          memAddr,
    output logic [3:0]           memStrobe,
    output logic [31:0]          memWdata,
    output logic                 doneValid,
    output logic [ID_BITS-1:0]   doneId,
    output logic                 doneWen,
    output logic [PREG_BITS-1:0] doneDst,
    output logic [31:0]          doneData,
    output logic                 doneExc,
    output ExcCode               doneExcCode,
    output logic [31:0]          doneBadAddr
);

    typedef enum logic [3:0] {
        Idle,
        Check,
        LoadReq,
        LoadRelease,
        StoreWait,
        StoreReq,
        StoreRelease,
        Drain,
        Done
    } LaneState;

    LaneState    state;
    MemOp        opR;
    logic [31:0] vaddr;
    logic [31:0] sdataR;
    logic [31:0] startAddr;
    logic        startBad;
    logic [31:0] mapped;
    logic        killed;
    logic [31:0] shifted;
    logic [31:0] loadValue;

    assign startAddr   = base + imm;
    assign startBad    = misaligned(op, startAddr[1:0]);
    assign mapped      = physAddr(vaddr);
    assign busy        = state != Idle;
    assign memReq      = state == LoadReq || state == StoreReq;
    assign memWrite    = isStore(opR);
    assign doneWen     = isLoad(opR) && !doneExc;
    assign doneExcCode = isStore(opR) ? ADES : ADEL;
    assign doneBadAddr = vaddr;

    ////////////////////////////////////////////////////////////
    // Load data extraction
    ////////////////////////////////////////////////////////////

    assign shifted = memRdata >> {vaddr[1:0], 3'b000};

    always_comb begin
        case (opR)
            LB:      loadValue = {{24{shifted[7]}}, shifted[7:0]};
            LBU:     loadValue = {24'h0, shifted[7:0]};
            LH:      loadValue = {{16{shifted[15]}}, shifted[15:0]};
            LHU:     loadValue = {16'h0, shifted[15:0]};
            default: loadValue = memRdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == Idle && start) begin
            opR     <= op;
            doneId  <= id;
            doneDst <= dst;
            vaddr   <= startAddr;
            sdataR  <= storeData;
            doneExc <= startBad;
        end
        // Physical word address and byte lanes settle in Check
        if (state == Check) begin
            memAddr  <= {mapped[31:2], 2'b00};
            memWdata <= sdataR << {vaddr[1:0], 3'b000};
            case (opR)
                SB:      memStrobe <= 4'b0001 << vaddr[1:0];
                SH:      memStrobe <= vaddr[1] ? 4'b1100 : 4'b0011;
                default: memStrobe <= 4'b1111;
            endcase
        end
        if (state == LoadReq && memAck) begin
            doneData <= loadValue;
        end
    end

    ////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= Idle;
            doneValid <= 1'b0;
            killed    <= 1'b0;
        end else begin
            if (doneTake) begin
                doneValid <= 1'b0;
            end
            case (state)
                Idle: begin
                    if (start && !flush) begin
                        killed <= 1'b0;
                        if (startBad) begin
                            state     <= Done;
                            doneValid <= 1'b1;
                        end else begin
                            state <= Check;
                        end
                    end
                end
                Check: begin
                    if (flush) begin
                        state <= Idle;
                    end else if (isLoad(opR)) begin
                        state <= LoadReq;
                    end else begin
                        // Stores report finish now and write after firing
                        state     <= isStore(opR) ? StoreWait : Done;
                        doneValid <= 1'b1;
                    end
                end
                LoadReq: begin
                    if (flush) begin
                        killed <= 1'b1;
                    end
                    if (memAck) begin
                        state <= (killed || flush) ? Drain : LoadRelease;
                    end
                end
                LoadRelease: begin
                    if (flush) begin
                        state <= Drain;
                    end else if (!memAck) begin
                        state     <= Done;
                        doneValid <= 1'b1;
                    end
                end
                Drain: begin
                    if (!memAck) begin
                        state <= Idle;
                    end
                end
                StoreWait: begin
                    if (fire) begin
                        state <= StoreReq;
                    end else if (flush) begin
                        state     <= Idle;
                        doneValid <= 1'b0;
                    end
                end
                StoreReq: begin
                    if (memAck) begin
                        state <= StoreRelease;
                    end
                end
                StoreRelease: begin
                    if (!memAck) begin
                        state <= Idle;
                    end
                end
                Done: begin
                    if (flush || doneTake) begin
                        state     <= Idle;
                        doneValid <= 1'b0;
                    end
                end
                default: state <= Idle;
            endcase
        end
    end

    // Four-phase rule toward memArbiter
    assert property (@(posedge clk) disable iff (rst) memReq && !memAck |=> memReq);

    // lsuIssue must only pick idle lanes
    assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

// File: design/memArbiter.sv
`default_nettype none

module memArbiter import lsuPkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [NUM_LANES-1:0]       memReq,
    input  logic [NUM_LANES-1:0]       memWrite,
    input  logic [NUM_LANES-1:0][31:0] memAddr,
    input  logic [NUM_LANES-1:0][3:0]  memStrobe,
    input  logic [NUM_LANES-1:0][31:0] memWdata,
    output logic [NUM_LANES-1:0]       memAck,
    output logic [NUM_LANES-1:0][31:0] memRdata
);

    logic [31:0]          ram [RAM_WORDS];
    logic [31:0]          rdata;
    logic                 held;
    logic [LANE_BITS-1:0] last;
    logic [LANE_BITS-1:0] next;
    logic                 found;
    logic [RAM_BITS-1:0]  index;

    // Search starts just after the last granted lane
    always_comb begin
        int idx;
        next  = last;
        found = 1'b0;
        for (int k = NUM_LANES; k >= 1; k--) begin
            idx = (int'(last) + k) % NUM_LANES;
            if (memReq[idx]) begin
                next  = LANE_BITS'(idx);
                found = 1'b1;
            end
        end
    end

    assign index = memAddr[next][RAM_BITS+1:2];

    // Grant stays with one lane until it drops memReq
    always_ff @(posedge clk) begin
        if (rst) begin
            held   <= 1'b0;
            last   <= '0;
            memAck <= '0;
        end else if (!held) begin
            if (found) begin
                held   <= 1'b1;
                last   <= next;
                memAck <= NUM_LANES'(1) << next;
            end
        end else if (!memReq[last]) begin
            held   <= 1'b0;
            memAck <= '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Data RAM, one access per grant
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!held && found) begin
            rdata <= ram[index];
            if (memWrite[next]) begin
                for (int b = 0; b < 4; b++) begin
                    if (memStrobe[next][b]) begin
                        ram[index][8*b +: 8] <= memWdata[next][8*b +: 8];
                    end
                end
            end
        end
    end

    // Read word is shared, each lane samples it under its own ack
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            memRdata[i] = rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $onehot0(memAck));

endmodule

`default_nettype wire

// File: design/commitArbiter.sv
`default_nettype none

module commitArbiter import lsuPkg::*; (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [NUM_LANES-1:0]                doneValid,
    input  logic [NUM_LANES-1:0][ID_BITS-1:0]   doneId,
    input  logic [NUM_LANES-1:0]                doneWen,
    input  logic [NUM_LANES-1:0][PREG_BITS-1:0] doneDst,
    input  logic [NUM_LANES-1:0][31:0]          doneData,
    input  logic [NUM_LANES-1:0]                doneExc,
    input  ExcCode [NUM_LANES-1:0]              doneExcCode,
    input  logic [NUM_LANES-1:0][31:0]          doneBadAddr,
    output logic [NUM_LANES-1:0]                doneTake,
    output logic                                commitValid,
    output logic [ID_BITS-1:0]                  commitId,
    output logic                                commitWen,
    output logic [PREG_BITS-1:0]                commitDst,
    output logic [31:0]                         commitData,
    output logic                                commitExc,
    output ExcCode                              commitExcCode,
    output logic [31:0]                         commitBadAddr
);

    logic [LANE_BITS-1:0] sel;

    // Lowest pending lane wins
    always_comb begin
        sel = '0;
        for (int i = NUM_LANES - 1; i >= 0; i--) begin
            if (doneValid[i]) begin
                sel = LANE_BITS'(i);
            end
        end
    end

    assign doneTake = doneValid & (NUM_LANES'(1) << sel);

    always_ff @(posedge clk) begin
        if (rst) begin
            commitValid <= 1'b0;
        end else begin
            commitValid <= |doneValid;
        end
    end

    always_ff @(posedge clk) begin
        commitId      <= doneId[sel];
        commitWen     <= doneWen[sel];
        commitDst     <= doneDst[sel];
        commitData    <= doneData[sel];
        commitExc     <= doneExc[sel];
        commitExcCode <= doneExcCode[sel];
        commitBadAddr <= doneBadAddr[sel];
    end

endmodule

`default_nettype wire

// File: design/lsuTop.sv
`default_nettype none

module lsuTop import lsuPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueReq,
    input  MemOp                 issueOp,
    input  logic [ID_BITS-1:0]   issueId,
    input  logic [PREG_BITS-1:0] issueDst,
    input  logic [31:0]          issueBase,
    input  logic [31:0]          issueImm,
    input  logic [31:0]          issueStoreData,
    output logic                 issueAck,
    input  logic                 fireStore,
    input  logic                 flush,
    output logic                 commitValid,
    output logic [ID_BITS-1:0]   commitId,
    output logic                 commitWen,
    output logic [PREG_BITS-1:0] commitDst,
    output logic [31:0]          commitData,
    output logic                 commitExc,
    output ExcCode               commitExcCode,
    output logic [31:0]          commitBadAddr
);

    logic [NUM_LANES-1:0]                laneBusy;
    logic [NUM_LANES-1:0]                laneStart;
    logic [NUM_LANES-1:0]                laneFire;
    MemOp                                laneOp;
    logic [ID_BITS-1:0]                  laneId;
    logic [PREG_BITS-1:0]                laneDst;
    logic [31:0]                         laneBase;
    logic [31:0]                         laneImm;
    logic [31:0]                         laneStoreData;

    logic [NUM_LANES-1:0]                memReq;
    logic [NUM_LANES-1:0]                memWrite;
    logic [NUM_LANES-1:0][31:0]          memAddr;
    logic [NUM_LANES-1:0][3:0]           memStrobe;
    logic [NUM_LANES-1:0][31:0]          memWdata;
    logic [NUM_LANES-1:0]                memAck;
    logic [NUM_LANES-1:0][31:0]          memRdata;

    logic [NUM_LANES-1:0]                doneValid;
    logic [NUM_LANES-1:0][ID_BITS-1:0]   doneId;
    logic [NUM_LANES-1:0]                doneWen;
    logic [NUM_LANES-1:0][PREG_BITS-1:0] doneDst;
    logic [NUM_LANES-1:0][31:0]          doneData;
    logic [NUM_LANES-1:0]                doneExc;
    ExcCode [NUM_LANES-1:0]              doneExcCode;
    logic [NUM_LANES-1:0][31:0]          doneBadAddr;
    logic [NUM_LANES-1:0]                doneTake;

    lsuIssue issue (.*);

    ////////////////////////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////////////////////////

    for (genvar g = 0; g < NUM_LANES; g++) begin : gLane
        lsuLane lane (
            .clk(clk),
            .rst(rst),
            .flush(flush),
            .start(laneStart[g]),
            .op(laneOp),
            .id(laneId),
            .dst(laneDst),
            .base(laneBase),
            .imm(laneImm),
            .storeData(laneStoreData),
            .fire(laneFire[g]),
            .memAck(memAck[g]),
            .memRdata(memRdata[g]),
            .doneTake(doneTake[g]),
            .busy(laneBusy[g]),
            .memReq(memReq[g]),
            .memWrite(memWrite[g]),
            .memAddr(memAddr[g]),
            .memStrobe(memStrobe[g]),
            .memWdata(memWdata[g]),
            .doneValid(doneValid[g]),
            .doneId(doneId[g]),
            .doneWen(doneWen[g]),
            .doneDst(doneDst[g]),
            .doneData(doneData[g]),
            .doneExc(doneExc[g]),
            .doneExcCode(doneExcCode[g]),
            .doneBadAddr(doneBadAddr[g])
        );
    end

    memArbiter mem (.*);

    commitArbiter commit (.*);

endmodule

`default_nettype wire

// File: test/lsuChecks.svh
`ifndef LSU_CHECKS_SVH
`define LSU_CHECKS_SVH

// Compare one value against its expected value
task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
        errorCount++;
        $display("error: %s is %h, expected %h", name, got, exp);
    end
endtask

// Galois LFSR, one step per bit taken
function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsrState[0]};
        lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'hD000_0001 : lfsrState >> 1;
    end
    return v;
endfunction

function automatic logic writesMemory(MemOp op);
    return op == SB || op == SH || op == SW;
endfunction

// Natural alignment of the access size
function automatic logic alignFault(MemOp op, logic [1:0] low);
    if (op == LW || op == SW) return low != 2'b00;
    if (op == LH || op == LHU || op == SH) return low[0];
    return 1'b0;
endfunction

// Both kseg windows fold onto physical zero
function automatic logic [31:0] mapWindow(logic [31:0] va);
    if (va >= KSEG1_BASE && va - KSEG1_BASE < 32'h2000_0000) return va - KSEG1_BASE;
    if (va >= KSEG0_BASE && va - KSEG0_BASE < 32'h2000_0000) return va - KSEG0_BASE;
    return va;
endfunction

function automatic logic [31:0] loadExtend(MemOp op, logic [31:0] word, logic [1:0] low);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*low +: 8];
    h = word[16*low[1] +: 16];
    case (op)
        LB:      return {{24{b[7]}}, b};
        LBU:     return {24'h0, b};
        LH:      return {{16{h[15]}}, h};
        LHU:     return {16'h0, h};
        default: return word;
    endcase
endfunction

function automatic logic [31:0] storeMerge(MemOp op, logic [31:0] old,
                                           logic [31:0] data, logic [1:0] low);
    logic [31:0] res;
    res = old;
    case (op)
        SB:      res[8*low +: 8] = data[7:0];
        SH:      res[16*low[1] +: 16] = data[15:0];
        default: res = data;
    endcase
    return res;
endfunction

`endif

// File: test/lsuTb.sv
`default_nettype none

module lsuTb
    import lsuPkg::*;
();

    localparam int MAX_STEPS = 64;

    typedef struct {
        MemOp        op;
        logic [31:0] base;
        logic [31:0] imm;
        logic [31:0] data;
        logic [31:0] expData;
        logic        expExc;
        logic        flushAfter;
    } Step;

    logic                 clk;
    logic                 rst;
    logic                 issueReq;
    MemOp                 issueOp;
    logic [ID_BITS-1:0]   issueId;
    logic [PREG_BITS-1:0] issueDst;
    logic [31:0]          issueBase;
    logic [31:0]          issueImm;
    logic [31:0]          issueStoreData;
    logic                 issueAck;
    logic                 fireStore;
    logic                 flush;
    logic                 commitValid;
    logic [ID_BITS-1:0]   commitId;
    logic                 commitWen;
    logic [PREG_BITS-1:0] commitDst;
    logic [31:0]          commitData;
    logic                 commitExc;
    ExcCode               commitExcCode;
    logic [31:0]          commitBadAddr;

    // Steps are indexed by ROB id, so they double as the expected-by-id table
    Step         steps [MAX_STEPS];
    bit          pending [MAX_STEPS];
    bit          allowed [MAX_STEPS];
    // Stores left unfired so that they keep their lanes busy
    bit          deferred [MAX_STEPS];
    logic [31:0] model [RAM_WORDS];
    logic [31:0] lfsrState = 32'h8ce1;
    int          numSteps = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          stallCount = 0;
    int          unfired = 0;
    bit          built = 1'b0;

    `include "lsuChecks.svh"

    lsuTop uut (.*);

    always #20 clk = ~clk;

    function automatic logic [PREG_BITS-1:0] dstFor(int id);
        return PREG_BITS'(63 - id);
    endfunction

    ////////////////////////////////////////////////////////////
    // Table construction with the reference model
    ////////////////////////////////////////////////////////////

    task automatic addStep(MemOp op, logic [31:0] base, logic [31:0] imm,
                           logic [31:0] data, logic flushAfter);
        Step                 s;
        logic [31:0]         va;
        logic [31:0]         phys;
        logic [RAM_BITS-1:0] idx;
        va           = base + imm;
        phys         = mapWindow(va);
        idx          = phys[RAM_BITS+1:2];
        s.op         = op;
        s.base       = base;
        s.imm        = imm;
        s.data       = data;
        s.expData    = '0;
        s.expExc     = alignFault(op, va[1:0]);
        // Faulting stores are followed by a flush, as the ROB would do
        s.flushAfter = flushAfter || (s.expExc && writesMemory(op));
        if (!s.expExc && writesMemory(op) && !flushAfter) begin
            model[idx] = storeMerge(op, model[idx], data, va[1:0]);
        end else if (!s.expExc && !writesMemory(op)) begin
            s.expData = loadExtend(op, model[idx], va[1:0]);
        end
        steps[numSteps] = s;
        numSteps++;
    endtask

    task automatic buildTable();
        logic [31:0] r;
        logic [31:0] imm;
        logic [31:0] data;
        addStep(SW, 32'h100, 0, randBits(32), 1'b0);
        addStep(LW, 32'h100, 0, 0, 1'b0);
        for (int w = 1; w < 5; w++) begin
            addStep(SW, 32'h100, 32'(4 * w), randBits(32), 1'b0);
        end
        // Byte and halfword merges, then every load flavor
        for (int b = 0; b < 4; b++) addStep(SB, 32'h104, 32'(b), randBits(32), 1'b0);
        addStep(SH, 32'h108, 0, randBits(32), 1'b0);
        addStep(SH, 32'h108, 2, randBits(32), 1'b0);
        addStep(LW, 32'h104, 0, 0, 1'b0);
        addStep(LW, 32'h108, 0, 0, 1'b0);
        for (int b = 0; b < 4; b++) addStep(LB, 32'h104, 32'(b), 0, 1'b0);
        for (int b = 0; b < 4; b++) addStep(LBU, 32'h104, 32'(b), 0, 1'b0);
        for (int b = 0; b < 4; b += 2) addStep(LH, 32'h108, 32'(b), 0, 1'b0);
        for (int b = 0; b < 4; b += 2) addStep(LHU, 32'h108, 32'(b), 0, 1'b0);
        // Address errors
        addStep(LW, 32'h100, 1, 0, 1'b0);
        addStep(LH, 32'h100, 3, 0, 1'b0);
        addStep(SW, 32'h100, 2, randBits(32), 1'b0);
        addStep(SH, 32'h100, 5, randBits(32), 1'b0);
        addStep(LW, 32'h100, 0, 0, 1'b0);
        // Window aliases
        addStep(SW, 32'h8000_0100, 12, randBits(32), 1'b0);
        addStep(LW, 32'hA000_0100, 12, 0, 1'b0);
        addStep(LW, 32'h100, 12, 0, 1'b0);
        addStep(SH, 32'hA000_0110, 2, randBits(32), 1'b0);
        addStep(LHU, 32'h8000_0110, 2, 0, 1'b0);
        addStep(LW, 32'h8000_0114, 32'hFFFF_FFFC, 0, 1'b0);
        // Flushed load and flushed unfired store
        addStep(LW, 32'h100, 0, 0, 1'b1);
        addStep(SW, 32'h104, 0, randBits(32), 1'b1);
        addStep(LW, 32'h104, 0, 0, 1'b0);
        // Unfired stores hold every lane, so the next issue must stall
        for (int k = 0; k < NUM_LANES; k++) begin
            addStep(SW, 32'h120, 32'(4 * k), randBits(32), 1'b0);
            deferred[numSteps - 1] = 1'b1;
        end
        // Back-to-back loads to fill the lanes
        addStep(LW, 32'h100, 0, 0, 1'b0);
        addStep(LB, 32'h105, 0, 0, 1'b0);
        addStep(LH, 32'h10a, 0, 0, 1'b0);
        addStep(LW, 32'h10c, 0, 0, 1'b0);
        addStep(LBU, 32'h113, 0, 0, 1'b0);
        addStep(LW, 32'h110, 0, 0, 1'b0);
        for (int k = 0; k < NUM_LANES; k++) begin
            addStep(LW, 32'h120, 32'(4 * k), 0, 1'b0);
        end
        while (numSteps < MAX_STEPS) begin
            r    = randBits(3);
            imm  = randBits(4);
            data = randBits(32);
            addStep(MemOp'(r[3:0]), 32'h100, imm, data, 1'b0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Driving
    ////////////////////////////////////////////////////////////

    task automatic driveIssue(int id);
        int waited;
        @(posedge clk);
        issueReq       <= 1'b1;
        issueOp        <= steps[id].op;
        issueId        <= ID_BITS'(id);
        issueDst       <= dstFor(id);
        issueBase      <= steps[id].base;
        issueImm       <= steps[id].imm;
        issueStoreData <= steps[id].data;
        @(negedge clk);
        waited = 1;
        while (!issueAck) begin
            @(negedge clk);
            waited++;
        end
        if (waited > 2) stallCount++;
        @(posedge clk);
        issueReq <= 1'b0;
        @(negedge clk);
        while (issueAck) @(negedge clk);
    endtask

    task automatic pulseFlush();
        @(posedge clk);
        flush <= 1'b1;
        // Anything in flight may now be dropped
        for (int k = 0; k < MAX_STEPS; k++) pending[k] = 1'b0;
        @(posedge clk);
        flush <= 1'b0;
    endtask

    task automatic pulseFire();
        @(posedge clk);
        fireStore <= 1'b1;
        @(posedge clk);
        fireStore <= 1'b0;
    endtask

    // Retire the held stores while an issue is stalled
    task automatic releaseStores();
        repeat (8) @(posedge clk);
        while (unfired > 0) begin
            pulseFire();
            unfired--;
        end
    endtask

    function automatic bit anyPending();
        for (int k = 0; k < MAX_STEPS; k++) begin
            if (pending[k]) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic waitDrained();
        while (anyPending()) @(negedge clk);
    endtask

    task automatic applyStep(int i);
        logic isStore;
        isStore = writesMemory(steps[i].op);
        if (isStore || steps[i].flushAfter) waitDrained();
        pending[i] = 1'b1;
        allowed[i] = 1'b1;
        if (unfired == NUM_LANES) begin
            fork
                driveIssue(i);
                releaseStores();
            join
        end else begin
            driveIssue(i);
        end
        if (steps[i].flushAfter) begin
            if (steps[i].expExc) begin
                while (pending[i]) @(negedge clk);
            end
            pulseFlush();
        end else if (isStore) begin
            // Retire the store only after it has finished
            while (pending[i]) @(negedge clk);
            if (deferred[i]) begin
                unfired++;
            end else begin
                pulseFire();
            end
        end
    endtask

    task automatic compareCommit(int id);
        Step  s;
        logic isStore;
        s       = steps[id];
        isStore = writesMemory(s.op);
        checkValue("commitExc", 32'(commitExc), 32'(s.expExc));
        checkValue("commitWen", 32'(commitWen), 32'(!isStore && !s.expExc));
        checkValue("commitDst", 32'(commitDst), 32'(dstFor(id)));
        if (s.expExc) begin
            checkValue("commitExcCode", 32'(commitExcCode), isStore ? 32'(ADES) : 32'(ADEL));
            checkValue("commitBadAddr", commitBadAddr, s.base + s.imm);
        end else if (!isStore) begin
            checkValue("commitData", commitData, s.expData);
        end
    endtask

    // Lanes finish out of order, so commits are matched by id
    always @(negedge clk) begin
        int id;
        if (!rst && commitValid) begin
            id = int'(commitId);
            if (!allowed[id]) begin
                errorCount++;
                $display("Commit for id %0d was not expected or arrived twice", id);
            end else begin
                allowed[id] = 1'b0;
                pending[id] = 1'b0;
                compareCommit(id);
            end
        end
    end

    initial begin
        wait (built);
        repeat (numSteps * 200) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped responding", numSteps * 200);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        issueReq       = 1'b0;
        issueOp        = NOP;
        issueId        = '0;
        issueDst       = '0;
        issueBase      = '0;
        issueImm       = '0;
        issueStoreData = '0;
        fireStore      = 1'b0;
        flush          = 1'b0;
        buildTable();
        built = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("issueAck", 32'(issueAck), 32'h0);
        checkValue("commitValid", 32'(commitValid), 32'h0);
        for (int i = 0; i < numSteps; i++) applyStep(i);
        waitDrained();
        // Short tail so a late duplicate commit is still seen
        repeat (10) @(posedge clk);
        if (stallCount == 0) begin
            errorCount++;
            $display("issueAck never stalled while all lanes were busy");
        end
        $display("Checks: %0d, errors: %0d, issue stalls: %0d",
                 checkCount, errorCount, stallCount);
        if (errorCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+test
design/lsuPkg.sv
design/lsuIssue.sv
design/lsuLane.sv
design/memArbiter.sv
design/commitArbiter.sv
design/lsuTop.sv
test/lsuTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert --top-module lsuTb -f build.f -o lsuSim; then
    echo "Verilator compile failed"
    exit 1
fi

if ! ./obj_dir/lsuSim > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1
